/* source/athr_pkg.sv */
package athr_pkg;

    // ------------------------------------------------------------
    // window geometry
    // ------------------------------------------------------------

    // edge of the square window and the index of its centre row and column.
    localparam int WIN_SIZE   = 17;
    localparam int WIN_CENTER = 8;

    // number of pixels covered by one window.
    localparam int WIN_AREA   = WIN_SIZE * WIN_SIZE;

    // ------------------------------------------------------------
    // data widths
    // ------------------------------------------------------------

    localparam int PIX_W      = 8;

    // one column word packs WIN_SIZE pixels, row 0 in the low byte.
    localparam int COL_W      = WIN_SIZE * PIX_W;

    // 17 * 255 fits in 13 bits and 289 * 255 fits in 17 bits.
    localparam int COLSUM_W   = 13;
    localparam int WINSUM_W   = 17;

    // column counter that saturates at WIN_SIZE.
    localparam int CNT_W      = $clog2(WIN_SIZE + 1);

    // (centre + offset) * 289, where centre + offset may reach 510.
    localparam int SCALED_W   = $clog2(WIN_AREA * (2 ** (PIX_W + 1) - 1) + 1);

    // ------------------------------------------------------------
    // pipeline latencies
    // ------------------------------------------------------------

    // registered levels of the column adder tree.
    localparam int TREE_LAT   = 5;

    // the running window sum adds one register after the tree.
    localparam int ACC_LAT    = 1;

endpackage

/* source/column_adder_tree.sv */
module column_adder_tree (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_valid,
    input  logic                           i_line_start,
    input  logic [athr_pkg::COL_W-1:0]     i_column,
    output logic                           o_sum_valid,
    output logic                           o_line_start,
    output logic [athr_pkg::COLSUM_W-1:0]  o_col_sum
);
    import athr_pkg::*;

    // partial sums, one array per level: 17 -> 9 -> 5 -> 3 -> 2 -> 1.
    logic [PIX_W:0]         lvl1 [0:8];
    logic [PIX_W+1:0]       lvl2 [0:4];
    logic [PIX_W+2:0]       lvl3 [0:2];
    logic [PIX_W+3:0]       lvl4 [0:1];
    logic [COLSUM_W-1:0]    col_sum;

    // valid and line-start tags travelling with the data.
    logic [TREE_LAT-1:0]    vld_sr;
    logic [TREE_LAT-1:0]    ls_sr;

    // ------------------------------------------------------------
    // adder levels
    // ------------------------------------------------------------

    // the tree runs every cycle; the tags decide which results count.
    always_ff @(posedge clk) begin
        for (int i = 0; i < WIN_SIZE / 2; i++) begin
            lvl1[i] <= {1'b0, i_column[2 * i * PIX_W +: PIX_W]}
                     + {1'b0, i_column[(2 * i + 1) * PIX_W +: PIX_W]};
        end
        // the odd pixel of row 16 rides along to the next level.
        lvl1[WIN_SIZE / 2] <= {1'b0, i_column[(WIN_SIZE - 1) * PIX_W +: PIX_W]};
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            lvl2[i] <= {1'b0, lvl1[2 * i]} + {1'b0, lvl1[2 * i + 1]};
        end
        lvl2[4] <= {1'b0, lvl1[8]};
    end

    always_ff @(posedge clk) begin
        lvl3[0] <= {1'b0, lvl2[0]} + {1'b0, lvl2[1]};
        lvl3[1] <= {1'b0, lvl2[2]} + {1'b0, lvl2[3]};
        lvl3[2] <= {1'b0, lvl2[4]};
    end

    always_ff @(posedge clk) begin
        lvl4[0] <= {1'b0, lvl3[0]} + {1'b0, lvl3[1]};
        lvl4[1] <= {1'b0, lvl3[2]};
    end

    always_ff @(posedge clk) begin
        col_sum <= {1'b0, lvl4[0]} + {1'b0, lvl4[1]};
    end

    // ------------------------------------------------------------
    // tags
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
            ls_sr  <= '0;
        end else begin
            vld_sr <= {vld_sr[TREE_LAT-2:0], i_valid};
            // a line start only counts on a strobed beat.
            ls_sr  <= {ls_sr[TREE_LAT-2:0], i_valid & i_line_start};
        end
    end

    assign o_sum_valid  = vld_sr[TREE_LAT-1];
    assign o_line_start = ls_sr[TREE_LAT-1];
    assign o_col_sum    = col_sum;

endmodule

/* source/window_accumulator.sv */
module window_accumulator (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_sum_valid,
    input  logic                           i_line_start,
    input  logic [athr_pkg::COLSUM_W-1:0]  i_col_sum,
    output logic                           o_sum_valid,
    output logic                           o_full,
    output logic [athr_pkg::WINSUM_W-1:0]  o_window_sum
);
    import athr_pkg::*;

    // hist[0] is the most recent column sum of the line.
    logic [COLSUM_W-1:0]  hist [0:WIN_SIZE-1];
    logic [CNT_W-1:0]     col_cnt;
    logic [WINSUM_W-1:0]  total;

    logic [COLSUM_W-1:0]  oldest;
    logic [CNT_W-1:0]     cnt_next;
    logic [WINSUM_W-1:0]  total_next;

    // ------------------------------------------------------------
    // next window sum
    // ------------------------------------------------------------

    // the oldest column only leaves the window once the line has
    // filled the whole history.
    always_comb begin
        oldest = (col_cnt == CNT_W'(WIN_SIZE)) ? hist[WIN_SIZE-1] : '0;
        if (i_line_start) begin
            cnt_next   = CNT_W'(1);
            total_next = WINSUM_W'(i_col_sum);
        end else begin
            if (col_cnt == CNT_W'(WIN_SIZE)) begin
                cnt_next = col_cnt;
            end else begin
                cnt_next = col_cnt + CNT_W'(1);
            end
            total_next = total + WINSUM_W'(i_col_sum) - WINSUM_W'(oldest);
        end
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (rst) begin
            col_cnt     <= '0;
            total       <= '0;
            o_sum_valid <= 1'b0;
            o_full      <= 1'b0;
            for (int i = 0; i < WIN_SIZE; i++) begin
                hist[i] <= '0;
            end
        end else begin
            o_sum_valid <= i_sum_valid;
            if (i_sum_valid) begin
                hist[0] <= i_col_sum;
                for (int i = 1; i < WIN_SIZE; i++) begin
                    hist[i] <= hist[i-1];
                end
                col_cnt <= cnt_next;
                total   <= total_next;
                // full once the column just added is the 17th of the line or later.
                o_full  <= (cnt_next == CNT_W'(WIN_SIZE));
            end
        end
    end

    assign o_window_sum = total;

endmodule

/* source/center_delay.sv */
module center_delay (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        i_valid,
    input  logic                        i_line_start,
    input  logic [athr_pkg::PIX_W-1:0]  i_center,
    output logic                        o_center_valid,
    output logic [athr_pkg::PIX_W-1:0]  o_center
);
    import athr_pkg::*;

    localparam int ALIGN_LAT = TREE_LAT + ACC_LAT;

    // fixed-latency shift that mirrors the tree and the accumulator.
    logic [PIX_W-1:0]      pix_sr [0:ALIGN_LAT-1];
    logic [ALIGN_LAT-1:0]  vld_sr;
    logic [ALIGN_LAT-1:0]  ls_sr;

    // centre pixels of the previous WIN_CENTER valid columns.
    logic [PIX_W-1:0]      hist [0:WIN_CENTER-1];

    always_ff @(posedge clk) begin
        pix_sr[0] <= i_center;
        for (int i = 1; i < ALIGN_LAT; i++) begin
            pix_sr[i] <= pix_sr[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            vld_sr <= '0;
            ls_sr  <= '0;
            for (int i = 0; i < WIN_CENTER; i++) begin
                hist[i] <= '0;
            end
        end else begin
            vld_sr <= {vld_sr[ALIGN_LAT-2:0], i_valid};
            ls_sr  <= {ls_sr[ALIGN_LAT-2:0], i_valid & i_line_start};
            if (vld_sr[ALIGN_LAT-1]) begin
                hist[0] <= pix_sr[ALIGN_LAT-1];
                // a new line drops the pixels of the previous one.
                for (int i = 1; i < WIN_CENTER; i++) begin
                    hist[i] <= ls_sr[ALIGN_LAT-1] ? '0 : hist[i-1];
                end
            end
        end
    end

    // the aligned column is the one WIN_CENTER beats behind the newest.
    assign o_center_valid = vld_sr[ALIGN_LAT-1];
    assign o_center       = hist[WIN_CENTER-1];

endmodule

/* source/threshold_decision.sv */
module threshold_decision (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_sum_valid,
    input  logic                           i_full,
    input  logic [athr_pkg::WINSUM_W-1:0]  i_window_sum,
    input  logic                           i_center_valid,
    input  logic [athr_pkg::PIX_W-1:0]     i_center,
    input  logic [athr_pkg::PIX_W-1:0]     i_offset,
    output logic                           o_valid,
    output logic                           o_bin,
    output logic [athr_pkg::PIX_W-1:0]     o_center,
    output logic [athr_pkg::WINSUM_W-1:0]  o_window_sum
);
    import athr_pkg::*;

    logic [PIX_W:0]     level;
    logic [SCALED_W-1:0] level_ext;
    logic [SCALED_W-1:0] scaled;

    // multiply by 289 as 256 + 32 + 1 so no multiplier is needed.
    always_comb begin
        level     = {1'b0, i_center} + {1'b0, i_offset};
        level_ext = SCALED_W'(level);
        scaled    = (level_ext << 8) + (level_ext << 5) + level_ext;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_sum_valid & i_full & i_center_valid;
        end
    end

    // foreground when centre plus offset is above the local mean.
    always_ff @(posedge clk) begin
        o_bin        <= (scaled > SCALED_W'(i_window_sum));
        o_center     <= i_center;
        o_window_sum <= i_window_sum;
    end

endmodule

/* source/adaptive_threshold_top.sv */
module adaptive_threshold_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_valid,
    input  logic                           i_line_start,
    input  logic [athr_pkg::COL_W-1:0]     i_column,
    input  logic [athr_pkg::PIX_W-1:0]     i_offset,
    output logic                           o_valid,
    output logic                           o_bin,
    output logic [athr_pkg::PIX_W-1:0]     o_center,
    output logic [athr_pkg::WINSUM_W-1:0]  o_window_sum
);
    import athr_pkg::*;

    logic                 tree_valid;
    logic                 tree_line_start;
    logic [COLSUM_W-1:0]  col_sum;

    logic                 acc_valid;
    logic                 acc_full;
    logic [WINSUM_W-1:0]  window_sum;

    logic                 ctr_valid;
    logic [PIX_W-1:0]     ctr_pixel;

    // ------------------------------------------------------------
    // window-sum path
    // ------------------------------------------------------------

    column_adder_tree u_tree (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_line_start (i_line_start),
        .i_column     (i_column),
        .o_sum_valid  (tree_valid),
        .o_line_start (tree_line_start),
        .o_col_sum    (col_sum)
    );

    window_accumulator u_acc (
        .clk          (clk),
        .rst          (rst),
        .i_sum_valid  (tree_valid),
        .i_line_start (tree_line_start),
        .i_col_sum    (col_sum),
        .o_sum_valid  (acc_valid),
        .o_full       (acc_full),
        .o_window_sum (window_sum)
    );

    // ------------------------------------------------------------
    // centre path, fed with row 8 of each column
    // ------------------------------------------------------------

    center_delay u_center (
        .clk            (clk),
        .rst            (rst),
        .i_valid        (i_valid),
        .i_line_start   (i_line_start),
        .i_center       (i_column[WIN_CENTER * PIX_W +: PIX_W]),
        .o_center_valid (ctr_valid),
        .o_center       (ctr_pixel)
    );

    threshold_decision u_decision (
        .clk            (clk),
        .rst            (rst),
        .i_sum_valid    (acc_valid),
        .i_full         (acc_full),
        .i_window_sum   (window_sum),
        .i_center_valid (ctr_valid),
        .i_center       (ctr_pixel),
        .i_offset       (i_offset),
        .o_valid        (o_valid),
        .o_bin          (o_bin),
        .o_center       (o_center),
        .o_window_sum   (o_window_sum)
    );

endmodule

/* testbench/adaptive_threshold_assert.sv */
module adaptive_threshold_assert (
    input  logic  clk,
    input  logic  rst,
    input  logic  i_valid,
    input  logic  i_line_start,
    input  logic  o_valid
);
    timeunit 1ns;
    timeprecision 100ps;

    import athr_pkg::*;

    // a strobed column reaches o_valid after the tree, the accumulator
    // and the decision register.
    localparam int OUT_LAT = TREE_LAT + ACC_LAT + 1;

    int                fail_count = 0;
    logic [CNT_W-1:0]  beat_cnt;
    logic [CNT_W-1:0]  beat_next;
    logic              full_strobe;

    // valid beats since the last line start, saturating at the window edge.
    always_comb begin
        if (i_line_start) begin
            beat_next = CNT_W'(1);
        end else if (beat_cnt == CNT_W'(WIN_SIZE)) begin
            beat_next = beat_cnt;
        end else begin
            beat_next = beat_cnt + CNT_W'(1);
        end
    end

    assign full_strobe = i_valid && (beat_next == CNT_W'(WIN_SIZE));

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_cnt <= '0;
        end else if (i_valid) begin
            beat_cnt <= beat_next;
        end
    end

    // ------------------------------------------------------------
    // output timing
    // ------------------------------------------------------------

    assert property (@(posedge clk) rst |=> !o_valid)
        else begin
            fail_count++;
            $error("o_valid high in the cycle after a reset cycle");
        end

    assert property (@(posedge clk) $fell(rst) |-> !o_valid [*OUT_LAT])
        else begin
            fail_count++;
            $error("o_valid high while the pipeline refills after reset");
        end

    assert property (@(posedge clk) disable iff (rst)
            o_valid |-> $past(beat_cnt, OUT_LAT - 1) == CNT_W'(WIN_SIZE))
        else begin
            fail_count++;
            $error("o_valid before 17 valid beats of the line");
        end

    assert property (@(posedge clk) disable iff (rst) full_strobe |-> ##OUT_LAT o_valid)
        else begin
            fail_count++;
            $error("no o_valid 7 cycles after a column that completes a window");
        end

    assert property (@(posedge clk) disable iff (rst) o_valid |-> $past(full_strobe, OUT_LAT))
        else begin
            fail_count++;
            $error("o_valid without a full window 7 cycles earlier");
        end

endmodule

bind adaptive_threshold_top adaptive_threshold_assert u_assert (
    .clk          (clk),
    .rst          (rst),
    .i_valid      (i_valid),
    .i_line_start (i_line_start),
    .o_valid      (o_valid)
);

/* testbench/adaptive_threshold_tb.sv */
module adaptive_threshold_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import athr_pkg::*;

    localparam string DATA_FILE    = "testbench/adaptive_threshold_testdata.txt";
    localparam int    RESET_CYCLES = 4;
    localparam int    WAIT_LIMIT   = 200;
    localparam int    IDLE_WATCH   = 16;

    logic                 clk;
    logic                 rst;
    logic                 i_valid;
    logic                 i_line_start;
    logic [COL_W-1:0]     i_column;
    logic [PIX_W-1:0]     i_offset;
    logic                 o_valid;
    logic                 o_bin;
    logic [PIX_W-1:0]     o_center;
    logic [WINSUM_W-1:0]  o_window_sum;

    // columns of the current test with their control fields.
    logic [COL_W-1:0]     col_q [$];
    bit                   ls_q [$];
    bit                   rst_q [$];
    int                   gap_q [$];

    // column sums and centre pixels of the line being modelled.
    int                   line_sum_q [$];
    int                   line_ctr_q [$];

    // expected outputs in the order the DUT must produce them.
    logic [WINSUM_W-1:0]  exp_sum_q [$];
    logic [PIX_W-1:0]     exp_ctr_q [$];
    logic                 exp_bin_q [$];

    string                test_name;
    logic [PIX_W-1:0]     test_offset;
    int                   test_mode;
    int                   out_index;
    int                   error_count;
    int                   check_count;
    int                   test_count;
    bit                   aborted;
    int                   fd;

    adaptive_threshold_top uut (
        .clk          (clk),
        .rst          (rst),
        .i_valid      (i_valid),
        .i_line_start (i_line_start),
        .i_column     (i_column),
        .i_offset     (i_offset),
        .o_valid      (o_valid),
        .o_bin        (o_bin),
        .o_center     (o_center),
        .o_window_sum (o_window_sum)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------

    function automatic int column_total(logic [COL_W-1:0] col);
        int total;
        total = 0;
        for (int r = 0; r < WIN_SIZE; r++) begin
            total += col[r * PIX_W +: PIX_W];
        end
        return total;
    endfunction

    // a full window covers the newest 17 columns of the line and is centred
    // on the column 8 beats back.
    task automatic add_column(logic [COL_W-1:0] col, bit ls, bit rs, int gap);
        int window;
        int centre;
        col_q.push_back(col);
        ls_q.push_back(ls);
        rst_q.push_back(rs);
        gap_q.push_back(gap);
        if (ls || rs) begin
            line_sum_q.delete();
            line_ctr_q.delete();
        end
        line_sum_q.push_back(column_total(col));
        line_ctr_q.push_back(int'(col[WIN_CENTER * PIX_W +: PIX_W]));
        if (line_sum_q.size() >= WIN_SIZE) begin
            window = 0;
            for (int k = line_sum_q.size() - WIN_SIZE; k < line_sum_q.size(); k++) begin
                window += line_sum_q[k];
            end
            centre = line_ctr_q[line_ctr_q.size() - 1 - WIN_CENTER];
            exp_sum_q.push_back(WINSUM_W'(window));
            exp_ctr_q.push_back(PIX_W'(centre));
            exp_bin_q.push_back((centre + int'(test_offset)) * WIN_AREA > window);
        end
    endtask

    // ------------------------------------------------------------
    // data file records
    // ------------------------------------------------------------

    task automatic read_header();
        void'($fscanf(fd, "%s %h %d", test_name, test_offset, test_mode));
        col_q.delete();
        ls_q.delete();
        rst_q.delete();
        gap_q.delete();
        line_sum_q.delete();
        line_ctr_q.delete();
        exp_sum_q.delete();
        exp_ctr_q.delete();
        exp_bin_q.delete();
    endtask

    task automatic read_columns();
        int               start;
        int               gap;
        int               count;
        int               step;
        int               extra;
        logic [COL_W-1:0] base;
        logic [COL_W-1:0] col;
        void'($fscanf(fd, "%d %d %d %d %h", start, gap, count, step, base));
        for (int c = 0; c < count; c++) begin
            for (int r = 0; r < WIN_SIZE; r++) begin
                if (test_mode == 2) begin
                    col[r * PIX_W +: PIX_W] = PIX_W'($urandom);
                end else begin
                    col[r * PIX_W +: PIX_W] = base[r * PIX_W +: PIX_W] + PIX_W'(c * step);
                end
            end
            extra = (test_mode == 1) ? int'($urandom % 4) : 0;
            add_column(col, (start == 1) && (c == 0), (start == 2) && (c == 0), gap + extra);
        end
    endtask

    task automatic read_expected();
        int                  idx;
        int                  bin;
        logic [PIX_W-1:0]    ctr;
        logic [WINSUM_W-1:0] sum;
        void'($fscanf(fd, "%d %d %h %h", idx, bin, ctr, sum));
        if (idx >= exp_sum_q.size() || exp_sum_q[idx] !== sum || exp_ctr_q[idx] !== ctr
                || exp_bin_q[idx] !== bin[0]) begin
            error_count++;
            $display("test %s: data file entry for output %0d disagrees with the threshold rule",
                     test_name, idx);
        end
    endtask

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------

    task automatic check_sum(logic [WINSUM_W-1:0] got, logic [WINSUM_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR o_window_sum got 0x%h expected 0x%h (test %s, output %0d)",
                     got, exp, test_name, out_index);
        end
    endtask

    task automatic check_center(logic [PIX_W-1:0] got, logic [PIX_W-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR o_center got 0x%h expected 0x%h (test %s, output %0d)",
                     got, exp, test_name, out_index);
        end
    endtask

    task automatic check_bin(logic got, logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("ERROR o_bin got 0x%h expected 0x%h (test %s, output %0d)",
                     got, exp, test_name, out_index);
        end
    endtask

    // ------------------------------------------------------------
    // stimulus and response
    // ------------------------------------------------------------

    task automatic pulse_reset();
        @(negedge clk);
        rst          = 1'b1;
        i_valid      = 1'b0;
        i_line_start = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        rst = 1'b0;
    endtask

    task automatic drive_columns();
        for (int i = 0; i < col_q.size(); i++) begin
            if (rst_q[i]) begin
                pulse_reset();
            end
            repeat (gap_q[i]) begin
                @(negedge clk);
                i_valid      = 1'b0;
                i_line_start = 1'b0;
            end
            @(negedge clk);
            i_valid      = 1'b1;
            i_line_start = ls_q[i];
            i_column     = col_q[i];
        end
        @(negedge clk);
        i_valid      = 1'b0;
        i_line_start = 1'b0;
    endtask

    task automatic collect_outputs();
        int waited;
        for (out_index = 0; out_index < exp_sum_q.size(); out_index++) begin
            waited = 0;
            @(negedge clk);
            while (o_valid !== 1'b1 && waited < WAIT_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (o_valid !== 1'b1) begin
                error_count++;
                aborted = 1'b1;
                $display("test %s: no o_valid within %0d cycles for output %0d",
                         test_name, WAIT_LIMIT, out_index);
                return;
            end
            check_sum(o_window_sum, exp_sum_q[out_index]);
            check_center(o_center, exp_ctr_q[out_index]);
            check_bin(o_bin, exp_bin_q[out_index]);
        end
    endtask

    // once the last window is out, the pipeline must stay quiet.
    task automatic watch_idle();
        repeat (IDLE_WATCH) begin
            @(negedge clk);
            if (o_valid !== 1'b0) begin
                error_count++;
                $display("test %s: o_valid pulsed after the last expected output", test_name);
            end
        end
    endtask

    task automatic run_test();
        int errors_before;
        errors_before = error_count;
        i_offset      = test_offset;
        fork
            drive_columns();
            collect_outputs();
        join
        if (!aborted) begin
            watch_idle();
        end
        test_count++;
        $display("test %-16s outputs %0d errors %0d",
                 test_name, exp_sum_q.size(), error_count - errors_before);
    endtask

    initial begin
        string tok;
        string rest;
        bit    have_test;
        rst          = 1'b1;
        i_valid      = 1'b0;
        i_line_start = 1'b0;
        i_column     = '0;
        i_offset     = '0;
        error_count  = 0;
        check_count  = 0;
        test_count   = 0;
        aborted      = 1'b0;
        have_test    = 1'b0;
        void'($urandom(25));
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            error_count++;
            $display("cannot open the stimulus file %s", DATA_FILE);
        end else begin
            repeat (RESET_CYCLES) @(negedge clk);
            rst = 1'b0;
            while (!aborted && $fscanf(fd, " %s", tok) == 1) begin
                if (tok.substr(0, 0) == "#") begin
                    void'($fgets(rest, fd));
                end else if (tok == "T") begin
                    if (have_test) begin
                        run_test();
                    end
                    read_header();
                    have_test = 1'b1;
                end else if (tok == "C") begin
                    read_columns();
                end else if (tok == "E") begin
                    read_expected();
                end else begin
                    error_count++;
                    aborted = 1'b1;
                    $display("unknown record %s in the stimulus file", tok);
                end
            end
            if (have_test && !aborted) begin
                run_test();
            end
            $fclose(fd);
        end
        error_count += uut.u_assert.fail_count;
        $display("tests %0d, checks %0d, assertion failures %0d, errors %0d",
                 test_count, check_count, uut.u_assert.fail_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* testbench/adaptive_threshold_testdata.txt */
# T name offset mode (mode 0 plain, 1 random idle gaps, 2 random pixels)
# C start gap count step column (start 1 line start, 2 reset first, step added per column)
# E output bin center window_sum (output index counted from the start of the test)
T const_mid 00 0
C 1 0 20 0 4040404040404040404040404040404040
E 0 0 40 4840
E 3 0 40 4840
T const_high 01 0
C 1 0 20 0 c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8c8
E 0 1 c8 e1c8
E 3 1 c8 e1c8
T const_max 00 0
C 1 0 18 0 ffffffffffffffffffffffffffffffffff
E 1 0 ff 11fdf
T ramp 00 0
C 1 0 24 4 100f0e0d0c0b0a09080706050403020100
E 0 0 28 2d28
E 7 0 44 4cc4
T line_restart 10 0
C 1 0 19 0 2020202020202020202020202020202020
C 1 0 18 0 6060606060606060606060606060606060
E 0 1 20 2420
E 2 1 20 2420
E 3 1 60 6c60
E 4 1 60 6c60
T ramp_gaps 00 1
C 1 1 24 4 100f0e0d0c0b0a09080706050403020100
E 0 0 28 2d28
E 7 0 44 4cc4
T random_image 04 2
C 1 0 80 0 0000000000000000000000000000000000
T reset_mid 00 0
C 1 0 12 0 3030303030303030303030303030303030
C 2 0 20 0 5050505050505050505050505050505050
E 0 0 50 5a50
E 3 0 50 5a50

/* filelist.f */
source/athr_pkg.sv
source/column_adder_tree.sv
source/window_accumulator.sv
source/center_delay.sv
source/threshold_decision.sv
source/adaptive_threshold_top.sv
testbench/adaptive_threshold_assert.sv
testbench/adaptive_threshold_tb.sv
